/* src/aq_pkg.sv */
package aq_pkg;

   // --------------------
   // Widths
   // --------------------

   // Host bus data path and address
   localparam int bus_width = 8;
   localparam int adr_width = 3;

   // Antenna sample as fetched from the source
   localparam int sample_width = 24;

   // Block size output and its log2 field
   localparam int accum_width = 32;
   localparam int log_width   = 5;

   // Acquisition sample delay field
   localparam int delay_width = 3;

   // --------------------
   // Prefetch queue
   // --------------------

   localparam int queue_depth       = 2;
   localparam int queue_ptr_width   = $clog2(queue_depth);
   // Occupancy counts 0 to queue_depth inclusive
   localparam int queue_level_width = $clog2(queue_depth + 1);

   // --------------------
   // Register map
   // --------------------

   // Antenna data read-back
   localparam logic [adr_width-1:0] ax_stream_adr = 3'd0;
   localparam logic [adr_width-1:0] ax_data1_adr  = 3'd1;
   localparam logic [adr_width-1:0] ax_data2_adr  = 3'd2;
   localparam logic [adr_width-1:0] ax_data3_adr  = 3'd3;
   // Visibility access and status
   localparam logic [adr_width-1:0] vx_stream_adr = 3'd4;
   localparam logic [adr_width-1:0] vx_status_adr = 3'd5;
   // Acquisition control
   localparam logic [adr_width-1:0] aq_debug_adr  = 3'd6;
   localparam logic [adr_width-1:0] aq_status_adr = 3'd7;

   // --------------------
   // Antenna sample word
   // --------------------

   // Byte view, most significant byte first on the stream
   typedef struct packed {
      logic [bus_width-1:0] hi;
      logic [bus_width-1:0] mid;
      logic [bus_width-1:0] lo;
   } sample_bytes_t;

   // Same 24 bits seen whole or split into bus bytes
   typedef union packed {
      logic [sample_width-1:0] word;
      sample_bytes_t           bytes;
   } sample_t;

endpackage

/* src/aq_sample_if.sv */
`timescale 1ns/1ps

interface aq_sample_if;

   // Head of the prefetch queue
   aq_pkg::sample_t sample;

   // Queue holds at least one sample
   logic valid;

   // Single-cycle pop request from the register stage
   // Ignored while valid is low
   logic taken;

   // Current occupancy, only watched by the assertions
   logic [aq_pkg::queue_level_width-1:0] level;

   // Prefetch side
   modport producer (
      output sample,
      output valid,
      output level,
      input  taken
   );

   // Register stage side
   modport consumer (
      input  sample,
      input  valid,
      output taken
   );

endinterface

/* src/aq_prefetch.sv */
`timescale 1ns/1ps

module aq_prefetch (
   input  logic                            clk_i,
   input  logic                            rst_i,
   // Sample source
   input  logic                            data_ready_i,
   input  logic [aq_pkg::sample_width-1:0] data_i,
   output logic                            data_request_o,
   // Queue head towards the register stage
   aq_sample_if.producer                   smp
);

   // --------------------
   // Storage and state
   // --------------------

   // Queue entries, payload only
   aq_pkg::sample_t mem [aq_pkg::queue_depth];

   logic [aq_pkg::queue_ptr_width-1:0]   wr_ptr;
   logic [aq_pkg::queue_ptr_width-1:0]   rd_ptr;
   logic [aq_pkg::queue_level_width-1:0] count;
   logic [aq_pkg::queue_level_width-1:0] count_next;

   logic            push;
   logic            pop;
   aq_pkg::sample_t in_word;

   // Source word taken as a whole sample
   always_comb in_word.word = data_i;

   // Source only delivers while asked, so request doubles as not-full
   assign push = data_ready_i && data_request_o;
   // Pop on an empty queue is dropped
   assign pop  = smp.taken && (count != '0);

   // --------------------
   // Occupancy
   // --------------------

   always_comb begin
      count_next = count;
      if (push && !pop) begin
         count_next = count + 1'b1;
      end else if (pop && !push) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         count <= '0;
      end else begin
         count <= count_next;
      end
   end

   // Registered request, low in reset, high the first cycle after
   // Tracks the next occupancy so it falls as the last slot fills
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_request_o <= 1'b0;
      end else begin
         data_request_o <= (count_next < aq_pkg::queue_depth);
      end
   end

   // --------------------
   // Pointers
   // --------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
      end else if (push) begin
         // Wrap at the last entry
         wr_ptr <= (wr_ptr == aq_pkg::queue_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= (rd_ptr == aq_pkg::queue_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
   end

   // Write the incoming word into the free slot
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= in_word;
      end
   end

   // --------------------
   // Queue head
   // --------------------

   assign smp.sample = mem[rd_ptr];
   assign smp.valid  = (count != '0);
   assign smp.level  = count;

endmodule

/* src/aq_regs.sv */
`timescale 1ns/1ps

module aq_regs (
   input  logic                             clk_i,
   input  logic                             rst_i,
   // Host bus, classic handshake
   input  logic                             cyc_i,
   input  logic                             stb_i,
   input  logic                             we_i,
   input  logic [aq_pkg::adr_width-1:0]     adr_i,
   input  logic [aq_pkg::bus_width-1:0]     dat_i,
   output logic                             ack_o,
   output logic [aq_pkg::bus_width-1:0]     dat_o,
   // Visibility bus
   output logic                             vx_cyc_o,
   output logic                             vx_stb_o,
   input  logic                             vx_ack_i,
   input  logic [aq_pkg::bus_width-1:0]     vx_dat_i,
   input  logic                             vx_available_i,
   input  logic                             vx_accessed_i,
   // Acquisition control and status
   input  logic                             spi_busy_i,
   output logic [aq_pkg::accum_width-1:0]   blocksize_o,
   output logic                             aq_debug_mode_o,
   output logic                             aq_enabled_o,
   output logic [aq_pkg::delay_width-1:0]   aq_sample_delay_o,
   // Samples from the prefetch stage
   aq_sample_if.consumer                    smp
);

   // --------------------
   // Local signals
   // --------------------

   logic                           req;
   logic                           wr;
   logic                           send;
   logic                           last_byte;
   logic [1:0]                     byte_idx;
   logic [aq_pkg::log_width-1:0]   log_block;
   aq_pkg::sample_t                head;
   logic [aq_pkg::bus_width-1:0]   stream_byte;
   logic [aq_pkg::bus_width-1:0]   rd_data;
   logic [aq_pkg::bus_width-1:0]   vx_status;
   logic [aq_pkg::bus_width-1:0]   aq_debug;
   logic [aq_pkg::bus_width-1:0]   aq_status;

   // New request, blocked during the ack cycle so each access acts once
   assign req = cyc_i && stb_i && !ack_o;
   assign wr  = req && we_i;

   // Read-back words
   assign vx_status = {vx_available_i, vx_accessed_i, 1'b0, log_block};
   assign aq_debug  = {aq_debug_mode_o,
                       {(aq_pkg::bus_width - 1 - aq_pkg::delay_width){1'b0}},
                       aq_sample_delay_o};
   assign aq_status = {{(aq_pkg::bus_width - 1){1'b0}}, aq_enabled_o};

   // --------------------
   // Bus acknowledge
   // --------------------

   // Local registers ack next cycle
   // Visibility reads wait for the far side's ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else if (req) begin
         ack_o <= (adr_i == aq_pkg::vx_stream_adr) ? vx_ack_i : 1'b1;
      end else begin
         ack_o <= 1'b0;
      end
   end

   // --------------------
   // Read mux
   // --------------------

   // Empty queue reads as zero
   assign head = smp.valid ? smp.sample : '0;

   // Stream byte, most significant first
   always_comb begin
      case (byte_idx)
         2'd0:    stream_byte = head.bytes.hi;
         2'd1:    stream_byte = head.bytes.mid;
         default: stream_byte = head.bytes.lo;
      endcase
   end

   always_comb begin
      case (adr_i)
         aq_pkg::ax_stream_adr: rd_data = stream_byte;
         aq_pkg::ax_data1_adr:  rd_data = head.bytes.hi;
         aq_pkg::ax_data2_adr:  rd_data = head.bytes.mid;
         aq_pkg::ax_data3_adr:  rd_data = head.bytes.lo;
         aq_pkg::vx_stream_adr: rd_data = vx_dat_i;
         aq_pkg::vx_status_adr: rd_data = vx_status;
         aq_pkg::aq_debug_adr:  rd_data = aq_debug;
         aq_pkg::aq_status_adr: rd_data = aq_status;
         default:               rd_data = '0;
      endcase
   end

   // Captured every waiting cycle, so a visibility read ends on the ack data
   always_ff @(posedge clk_i) begin
      if (req && !we_i) begin
         dat_o <= rd_data;
      end
   end

   // --------------------
   // Control registers
   // --------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         aq_enabled_o      <= 1'b0;
         aq_debug_mode_o   <= 1'b0;
         aq_sample_delay_o <= '0;
         log_block         <= '0;
      end else if (wr) begin
         case (adr_i)
            aq_pkg::vx_status_adr: begin
               log_block <= dat_i[aq_pkg::log_width-1:0];
            end
            aq_pkg::aq_debug_adr: begin
               aq_debug_mode_o   <= dat_i[aq_pkg::bus_width-1];
               aq_sample_delay_o <= dat_i[aq_pkg::delay_width-1:0];
            end
            aq_pkg::aq_status_adr: begin
               aq_enabled_o <= dat_i[0];
            end
            default: begin
               // Stream and data registers are read-only
            end
         endcase
      end
   end

   // Block size is 2**log_block - 1, one cycle behind the log register
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         blocksize_o <= '0;
      end else begin
         blocksize_o <= ~({aq_pkg::accum_width{1'b1}} << log_block);
      end
   end

   // --------------------
   // Byte serializer
   // --------------------

   // Stream read with a sample present
   assign send      = req && !we_i && (adr_i == aq_pkg::ax_stream_adr) && smp.valid;
   assign last_byte = (byte_idx == 2'd2);

   // Pop after the lo byte; no pop while the index is held at zero
   assign smp.taken = send && last_byte && spi_busy_i;

   // Idle SPI restarts the sample at its hi byte
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i) begin
         byte_idx <= 2'd0;
      end else if (send) begin
         byte_idx <= last_byte ? 2'd0 : byte_idx + 2'd1;
      end
   end

   // --------------------
   // Visibility forwarding
   // --------------------

   assign vx_cyc_o = cyc_i;
   // Strobe drops with the ack so the far side sees one request
   assign vx_stb_o = req && (adr_i == aq_pkg::vx_stream_adr);

endmodule

/* src/aq_ctrl.sv */
`timescale 1ns/1ps

module aq_ctrl (
   input  logic                             clk_i,
   input  logic                             rst_i,
   // Host bus
   input  logic                             cyc_i,
   input  logic                             stb_i,
   input  logic                             we_i,
   input  logic [aq_pkg::adr_width-1:0]     adr_i,
   input  logic [aq_pkg::bus_width-1:0]     dat_i,
   output logic                             ack_o,
   output logic [aq_pkg::bus_width-1:0]     dat_o,
   // Visibility bus
   output logic                             vx_cyc_o,
   output logic                             vx_stb_o,
   input  logic                             vx_ack_i,
   input  logic [aq_pkg::bus_width-1:0]     vx_dat_i,
   input  logic                             vx_available_i,
   input  logic                             vx_accessed_i,
   // Sample source
   output logic                             data_request_o,
   input  logic                             data_ready_i,
   input  logic [aq_pkg::sample_width-1:0]  data_i,
   input  logic                             spi_busy_i,
   // Acquisition control
   output logic [aq_pkg::accum_width-1:0]   blocksize_o,
   output logic                             aq_debug_mode_o,
   output logic                             aq_enabled_o,
   output logic [aq_pkg::delay_width-1:0]   aq_sample_delay_o
);

   // Prefetch to register stage link
   aq_sample_if smp_if ();

   // Stage 1, keeps the queue topped up from the source
   aq_prefetch prefetch_inst (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .data_ready_i   (data_ready_i),
      .data_i         (data_i),
      .data_request_o (data_request_o),
      .smp            (smp_if.producer)
   );

   // Stage 2, bus decode, serializer and control registers
   aq_regs regs_inst (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .cyc_i             (cyc_i),
      .stb_i             (stb_i),
      .we_i              (we_i),
      .adr_i             (adr_i),
      .dat_i             (dat_i),
      .ack_o             (ack_o),
      .dat_o             (dat_o),
      .vx_cyc_o          (vx_cyc_o),
      .vx_stb_o          (vx_stb_o),
      .vx_ack_i          (vx_ack_i),
      .vx_dat_i          (vx_dat_i),
      .vx_available_i    (vx_available_i),
      .vx_accessed_i     (vx_accessed_i),
      .spi_busy_i        (spi_busy_i),
      .blocksize_o       (blocksize_o),
      .aq_debug_mode_o   (aq_debug_mode_o),
      .aq_enabled_o      (aq_enabled_o),
      .aq_sample_delay_o (aq_sample_delay_o),
      .smp               (smp_if.consumer)
   );

endmodule

/* tb/aq_asserts.sv */
`timescale 1ns/1ps

module aq_asserts (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 ack_i,
   input  logic                                 vx_ack_i,
   input  logic                                 vx_stb_i,
   input  logic                                 push_i,
   input  logic [aq_pkg::queue_level_width-1:0] level_i
);

   // Failed properties, summed by the testbench at the end
   int violations = 0;

   // Host ack is a one-cycle pulse
   ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
      else begin
         violations++;
         $error("host ack held longer than one cycle");
      end

   // Visibility ack ends the strobe and acks the host next cycle
   vx_ack_follow: assert property (@(posedge clk_i) disable iff (rst_i)
                                   (vx_stb_i && vx_ack_i) |=> (ack_i && !vx_stb_i))
      else begin
         violations++;
         $error("host ack or strobe release missing after visibility ack");
      end

   // Full queue accepts nothing
   no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
                                  push_i |-> (level_i < aq_pkg::queue_depth))
      else begin
         violations++;
         $error("source word pushed into a full queue");
      end

   level_bound: assert property (@(posedge clk_i) disable iff (rst_i)
                                 level_i <= aq_pkg::queue_depth)
      else begin
         violations++;
         $error("queue level above its depth");
      end

endmodule

// Bus side checks on the register stage
bind aq_regs aq_asserts regs_chk (
   .clk_i    (clk_i),
   .rst_i    (rst_i),
   .ack_i    (ack_o),
   .vx_ack_i (vx_ack_i),
   .vx_stb_i (vx_stb_o),
   .push_i   (1'b0),
   .level_i  ('0)
);

// Queue side checks on the prefetch stage
bind aq_prefetch aq_asserts fifo_chk (
   .clk_i    (clk_i),
   .rst_i    (rst_i),
   .ack_i    (1'b0),
   .vx_ack_i (1'b0),
   .vx_stb_i (1'b0),
   .push_i   (push),
   .level_i  (count)
);

/* tb/aq_checker.sv */
`timescale 1ns/1ps

module aq_checker (
   input  logic                            clk_i,
   input  logic                            rst_i,
   input  logic                            cyc_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic [aq_pkg::adr_width-1:0]    adr_i,
   input  logic [aq_pkg::bus_width-1:0]    wdat_i,
   input  logic                            ack_i,
   input  logic [aq_pkg::bus_width-1:0]    rdat_i,
   input  logic                            vx_cyc_i,
   input  logic                            vx_stb_i,
   input  logic                            vx_ack_i,
   input  logic [aq_pkg::bus_width-1:0]    vx_dat_i,
   input  logic                            vx_available_i,
   input  logic                            vx_accessed_i,
   input  logic                            data_request_i,
   input  logic                            data_ready_i,
   input  logic [aq_pkg::sample_width-1:0] data_i,
   input  logic                            spi_busy_i,
   input  logic [aq_pkg::accum_width-1:0]  blocksize_i,
   input  logic                            debug_mode_i,
   input  logic                            enabled_i,
   input  logic [aq_pkg::delay_width-1:0]  sample_delay_i,
   output int                              checks_o,
   output int                              errors_o
);

   // --------------------
   // Modelled state
   // --------------------

   aq_pkg::sample_t                sent [$];
   logic [aq_pkg::bus_width-1:0]   vis [$];
   logic [1:0]                     idx;
   logic [aq_pkg::log_width-1:0]   log_m;
   // Log value one edge back, block size lags by a cycle
   logic [aq_pkg::log_width-1:0]   log_d;
   logic                           en_m;
   logic                           dbg_m;
   logic [aq_pkg::delay_width-1:0] dly_m;
   // Access finished, its ack is due next cycle
   logic                           pend;
   logic                           pend_rd;
   logic [aq_pkg::bus_width-1:0]   pend_exp;
   logic [aq_pkg::adr_width-1:0]   pend_adr;
   // First cycle out of reset, request still low
   logic                           first_cycle;

   initial begin
      checks_o = 0;
      errors_o = 0;
   end

   // Byte the host should see for a read at this address
   function automatic logic [7:0] expected_read(input logic [2:0] adr,
                                                input aq_pkg::sample_t head,
                                                input logic [1:0] byte_sel,
                                                input logic [7:0] vis_byte);
      logic [7:0] r;
      case (adr)
         aq_pkg::ax_stream_adr: begin
            r = (byte_sel == 2'd0) ? head.bytes.hi :
                (byte_sel == 2'd1) ? head.bytes.mid : head.bytes.lo;
         end
         aq_pkg::ax_data1_adr:  r = head.bytes.hi;
         aq_pkg::ax_data2_adr:  r = head.bytes.mid;
         aq_pkg::ax_data3_adr:  r = head.bytes.lo;
         aq_pkg::vx_stream_adr: r = vis_byte;
         aq_pkg::vx_status_adr: r = {vx_available_i, vx_accessed_i, 1'b0, log_m};
         aq_pkg::aq_debug_adr:  r = {dbg_m, 4'b0000, dly_m};
         default:               r = {7'b0000000, en_m};
      endcase
      return r;
   endfunction

   // --------------------
   // Compare process
   // --------------------

   always @(posedge clk_i) begin
      aq_pkg::sample_t head;
      aq_pkg::sample_t word_in;
      logic [7:0]      vis_byte;
      logic            done;
      logic            vis_req;
      if (rst_i) begin
         sent.delete();
         vis.delete();
         idx         = 2'd0;
         log_m       = '0;
         log_d       = '0;
         en_m        = 1'b0;
         dbg_m       = 1'b0;
         dly_m       = '0;
         pend        = 1'b0;
         first_cycle = 1'b1;
      end else begin
         // Request while a queue slot is free
         if (data_request_i !== (!first_cycle && sent.size() < aq_pkg::queue_depth)) begin
            errors_o++;
            $display("mismatch at %0t: data request %b with %0d words queued",
                     $time, data_request_i, sent.size());
         end
         first_cycle = 1'b0;
         // Strobe while a visibility request waits, cycle framed by the host cycle
         vis_req = cyc_i && stb_i && !ack_i && (adr_i == aq_pkg::vx_stream_adr);
         if (vx_stb_i !== vis_req || (vis_req && vx_cyc_i !== 1'b1) ||
             (!cyc_i && vx_cyc_i !== 1'b0)) begin
            errors_o++;
            $display("mismatch at %0t: visibility strobe %b cycle %b expected strobe %b",
                     $time, vx_stb_i, vx_cyc_i, vis_req);
         end
         // Ack of the access finished last cycle
         if (ack_i && !pend) begin
            errors_o++;
            $display("error at %0t: ack without a pending access", $time);
         end else if (pend && !ack_i) begin
            errors_o++;
            $display("error at %0t: ack missing for address %0d", $time, pend_adr);
         end else if (pend && pend_rd) begin
            checks_o++;
            if (rdat_i !== pend_exp) begin
               errors_o++;
               $display("mismatch at %0t: read adr %0d got %h expected %h",
                        $time, pend_adr, rdat_i, pend_exp);
            end
         end
         pend = 1'b0;
         // Control outputs against the model
         if (blocksize_i !== (33'd1 << log_d) - 33'd1) begin
            errors_o++;
            $display("mismatch at %0t: blocksize %h for log %0d", $time, blocksize_i, log_d);
         end
         if ({debug_mode_i, sample_delay_i, enabled_i} !== {dbg_m, dly_m, en_m}) begin
            errors_o++;
            $display("mismatch at %0t: control outputs %b%b%b expected %b%b%b", $time,
                     debug_mode_i, sample_delay_i, enabled_i, dbg_m, dly_m, en_m);
         end
         log_d = log_m;
         // Visibility data handed over
         if (vx_stb_i && vx_ack_i) begin
            vis.push_back(vx_dat_i);
         end
         // Local access ends now, visibility access ends with the far ack
         done = cyc_i && stb_i && !ack_i && (adr_i != aq_pkg::vx_stream_adr || vx_ack_i);
         if (done) begin
            head     = (sent.size() != 0) ? sent[0] : '0;
            vis_byte = (vis.size() != 0) ? vis[0] : 8'h00;
            pend     = 1'b1;
            pend_rd  = !we_i;
            pend_adr = adr_i;
            if (we_i) begin
               case (adr_i)
                  aq_pkg::vx_status_adr: log_m = wdat_i[4:0];
                  aq_pkg::aq_debug_adr: begin
                     dbg_m = wdat_i[7];
                     dly_m = wdat_i[2:0];
                  end
                  aq_pkg::aq_status_adr: en_m = wdat_i[0];
                  default: ;
               endcase
            end else begin
               pend_exp = expected_read(adr_i, head, idx, vis_byte);
               if (adr_i == aq_pkg::vx_stream_adr && vis.size() != 0) begin
                  void'(vis.pop_front());
               end
               // Stream byte consumed, sample popped after its lo byte
               if (adr_i == aq_pkg::ax_stream_adr && sent.size() != 0 && spi_busy_i) begin
                  if (idx == 2'd2) begin
                     idx = 2'd0;
                     void'(sent.pop_front());
                  end else begin
                     idx = idx + 2'd1;
                  end
               end
            end
         end
         // Idle SPI restarts the sample
         if (!spi_busy_i) begin
            idx = 2'd0;
         end
         // Word accepted from the source
         if (data_ready_i && data_request_i) begin
            word_in.word = data_i;
            sent.push_back(word_in);
            if (sent.size() > aq_pkg::queue_depth) begin
               errors_o++;
               $display("error at %0t: more than two source words accepted ahead", $time);
            end
         end
      end
   end

endmodule

/* tb/aq_tb.sv */
`timescale 1ns/1ps

module aq_tb;

   // Cycles allowed for any single wait
   localparam int wait_limit = 200;

   logic                             clk_i;
   logic                             rst_i;
   logic                             cyc_i;
   logic                             stb_i;
   logic                             we_i;
   logic [aq_pkg::adr_width-1:0]     adr_i;
   logic [aq_pkg::bus_width-1:0]     dat_i;
   logic                             ack_o;
   logic [aq_pkg::bus_width-1:0]     dat_o;
   logic                             vx_cyc_o;
   logic                             vx_stb_o;
   logic                             vx_ack_i;
   logic [aq_pkg::bus_width-1:0]     vx_dat_i;
   logic                             vx_available_i;
   logic                             vx_accessed_i;
   logic                             data_request_o;
   logic                             data_ready_i;
   logic [aq_pkg::sample_width-1:0]  data_i;
   logic                             spi_busy_i;
   logic [aq_pkg::accum_width-1:0]   blocksize_o;
   logic                             aq_debug_mode_o;
   logic                             aq_enabled_o;
   logic [aq_pkg::delay_width-1:0]   aq_sample_delay_o;

   // Model state
   logic [31:0] src_state;
   logic [31:0] vis_state;
   logic        src_stall;
   int          vis_cnt;
   int          vis_delay;
   int          checks;
   int          errors;
   int          violations;

   aq_ctrl aq_ctrl_inst (.*);

   aq_checker checker_inst (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .wdat_i         (dat_i),
      .ack_i          (ack_o),
      .rdat_i         (dat_o),
      .vx_cyc_i       (vx_cyc_o),
      .vx_stb_i       (vx_stb_o),
      .vx_ack_i       (vx_ack_i),
      .vx_dat_i       (vx_dat_i),
      .vx_available_i (vx_available_i),
      .vx_accessed_i  (vx_accessed_i),
      .data_request_i (data_request_o),
      .data_ready_i   (data_ready_i),
      .data_i         (data_i),
      .spi_busy_i     (spi_busy_i),
      .blocksize_i    (blocksize_o),
      .debug_mode_i   (aq_debug_mode_o),
      .enabled_i      (aq_enabled_o),
      .sample_delay_i (aq_sample_delay_o),
      .checks_o       (checks),
      .errors_o       (errors)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   initial begin
      clk_i = 1'b0;
      forever begin
         #5 clk_i = ~clk_i;
      end
   end

   // --------------------
   // Source and visibility models
   // --------------------

   // Offers a word at random and holds it until accepted
   always @(posedge clk_i) begin
      if (rst_i || src_stall) begin
         data_ready_i <= 1'b0;
      end else if (!data_ready_i || data_request_o) begin
         src_state = xorshift(src_state);
         data_ready_i <= (src_state[1:0] != 2'b00);
         data_i       <= src_state[31:8];
      end
   end

   // Acks a strobe after 1 to 4 cycles
   always @(posedge clk_i) begin
      if (rst_i || !vx_stb_o || vx_ack_i) begin
         vx_ack_i <= 1'b0;
         vis_cnt = 0;
      end else if (vis_cnt + 1 >= vis_delay) begin
         vis_state = xorshift(vis_state);
         vx_ack_i  <= 1'b1;
         vx_dat_i  <= vis_state[15:8];
         vis_delay = vis_state[1:0] + 1;
         vis_cnt   = 0;
      end else begin
         vis_cnt = vis_cnt + 1;
      end
   end

   // --------------------
   // Bus driver
   // --------------------

   task automatic bus_access(input logic we, input logic [2:0] adr, input logic [7:0] wdat);
      int n;
      @(posedge clk_i);
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= we;
      adr_i <= adr;
      dat_i <= wdat;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
      end while (!ack_o && n < wait_limit);
      if (ack_o) begin
         cyc_i <= 1'b0;
         stb_i <= 1'b0;
         we_i  <= 1'b0;
      end else begin
         $display("timeout: no bus ack for address %0d", adr);
         $display("Testbench failed");
         $finish;
      end
   endtask

   task automatic write_reg(input logic [2:0] adr, input logic [7:0] wdat);
      bus_access(1'b1, adr, wdat);
   endtask

   task automatic read_reg(input logic [2:0] adr);
      bus_access(1'b0, adr, 8'h00);
   endtask

   // Lets the source fill the queue until the request drops
   task automatic wait_queue_full();
      int n;
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
      end while (data_request_o && n < wait_limit);
      if (data_request_o) begin
         $display("timeout: prefetch queue never filled");
         $display("Testbench failed");
         $finish;
      end
   endtask

   task automatic do_reset();
      rst_i <= 1'b1;
      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;
   endtask

   // --------------------
   // Stimulus
   // --------------------

   initial begin
      rst_i          = 1'b1;
      cyc_i          = 1'b0;
      stb_i          = 1'b0;
      we_i           = 1'b0;
      adr_i          = '0;
      dat_i          = '0;
      vx_ack_i       = 1'b0;
      vx_dat_i       = '0;
      vx_available_i = 1'b0;
      vx_accessed_i  = 1'b0;
      data_ready_i   = 1'b0;
      data_i         = '0;
      spi_busy_i     = 1'b1;
      src_stall      = 1'b0;
      src_state      = 32'd50;
      vis_state      = xorshift(32'd50);
      vis_delay      = 1;
      vis_cnt        = 0;
      do_reset();
      // Control and debug registers
      write_reg(aq_pkg::aq_debug_adr, 8'h85);
      read_reg(aq_pkg::aq_debug_adr);
      write_reg(aq_pkg::aq_debug_adr, 8'h7a);
      read_reg(aq_pkg::aq_debug_adr);
      write_reg(aq_pkg::aq_status_adr, 8'h03);
      read_reg(aq_pkg::aq_status_adr);
      // Block size from log, status bits follow the inputs
      for (int i = 0; i < 4; i++) begin
         vx_available_i <= i[0];
         vx_accessed_i  <= i[1];
         write_reg(aq_pkg::vx_status_adr, (i == 3) ? 8'd31 : 8'(i * 7));
         read_reg(aq_pkg::vx_status_adr);
      end
      // Full queue, peek registers, then the byte stream
      wait_queue_full();
      read_reg(aq_pkg::ax_data1_adr);
      read_reg(aq_pkg::ax_data2_adr);
      read_reg(aq_pkg::ax_data3_adr);
      repeat (12) read_reg(aq_pkg::ax_stream_adr);
      // SPI idle in the middle of a sample
      read_reg(aq_pkg::ax_stream_adr);
      spi_busy_i <= 1'b0;
      @(posedge clk_i);
      spi_busy_i <= 1'b1;
      repeat (3) read_reg(aq_pkg::ax_stream_adr);
      // Visibility reads
      repeat (5) read_reg(aq_pkg::vx_stream_adr);
      // Stalled source drains the queue into zero reads
      src_stall <= 1'b1;
      repeat (10) read_reg(aq_pkg::ax_stream_adr);
      read_reg(aq_pkg::ax_data1_adr);
      src_stall <= 1'b0;
      wait_queue_full();
      repeat (9) read_reg(aq_pkg::ax_stream_adr);
      // Second reset clears the control registers
      do_reset();
      read_reg(aq_pkg::aq_debug_adr);
      read_reg(aq_pkg::aq_status_adr);
      read_reg(aq_pkg::vx_status_adr);
      repeat (2) @(posedge clk_i);
      violations = aq_ctrl_inst.regs_inst.regs_chk.violations +
                   aq_ctrl_inst.prefetch_inst.fifo_chk.violations;
      $display("reads checked %0d, errors %0d, assertion failures %0d",
               checks, errors, violations);
      if (errors == 0 && violations == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* aq_ctrl.f */
src/aq_pkg.sv
src/aq_sample_if.sv
src/aq_prefetch.sv
src/aq_regs.sv
src/aq_ctrl.sv
tb/aq_asserts.sv
tb/aq_checker.sv
tb/aq_tb.sv
